// File: verilog/irq_pkg.sv
package irq_pkg;

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  typedef logic [4:0]  irq_id_t;                // Interrupt id, also the mcause code
  typedef logic [11:0] csr_addr_t;              // CSR address as in the csrrw encoding

  ////////////////////////////////////////
  // Interrupt line map
  ////////////////////////////////////////

  // Standard machine interrupt positions in mie/mip
  parameter logic [4:0] CSR_MSIX_BIT = 5'd3;    // Machine software interrupt
  parameter logic [4:0] CSR_MTIX_BIT = 5'd7;    // Machine timer interrupt
  parameter logic [4:0] CSR_MEIX_BIT = 5'd11;   // Machine external interrupt

  // Implemented lines
  // Bits 31..16 are the custom fast lines
  // Bits 11, 7 and 3 are MEI, MTI and MSI
  // All other lines are reserved and read as zero
  parameter logic [31:0] IRQ_MASK_DEFAULT = {
    16'hffff,                                   // Custom 31..16
    4'b0000,                                    // Reserved 15..12
    4'b1000,                                    // MEI at 11
    4'b1000,                                    // MTI at 7
    4'b1000                                     // MSI at 3
  };

  ////////////////////////////////////////
  // mstatus fields
  ////////////////////////////////////////

  // Only the two enable bits exist in this machine-only core
  parameter int unsigned MSTATUS_MIE_BIT  = 3;  // Global machine interrupt enable
  parameter int unsigned MSTATUS_MPIE_BIT = 7;  // MIE value saved at trap entry

  ////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////

  // Machine trap setup
  parameter csr_addr_t CSR_MSTATUS = 12'h300;
  parameter csr_addr_t CSR_MIE     = 12'h304;
  parameter csr_addr_t CSR_MTVEC   = 12'h305;

  // Machine trap handling
  parameter csr_addr_t CSR_MEPC    = 12'h341;
  parameter csr_addr_t CSR_MCAUSE  = 12'h342;
  parameter csr_addr_t CSR_MIP     = 12'h344;   // Read only, writes are dropped

  // Any other address reads zero and ignores writes

endpackage

// File: verilog/irq_ctrl.sv
`timescale 1ns/1ns

module irq_ctrl #(
  parameter logic [31:0] IRQ_MASK = irq_pkg::IRQ_MASK_DEFAULT  // Implemented lines
) (
  input  logic              clk,
  input  logic              rst_n,

  // Level-triggered lines from outside
  input  logic [31:0]       irq_i,

  // From the CSR unit
  input  logic [31:0]       mie_i,              // Per-line enables
  input  logic              m_irq_enable_i,     // mstatus.MIE

  // To the CSR unit and trap control
  output logic [31:0]       mip_o,              // Registered pending lines
  output logic              irq_req_o,          // Interrupt may be taken
  output irq_pkg::irq_id_t  irq_id_o,           // Highest-priority pending id

  // To the outside
  output logic              irq_wu_o            // Unregistered wake-up
);

  import irq_pkg::*;

  logic [31:0] irq_q;                           // Masked lines, one cycle late
  logic [31:0] irq_qual;                        // Pending and locally enabled

  ////////////////////////////////////////
  // Line capture
  ////////////////////////////////////////

  // Everything except the wake-up works from the registered copy,
  // so there is no combinational path from irq_i to the core
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_i & IRQ_MASK;                // Reserved lines never show up
    end
  end

  assign mip_o    = irq_q;                      // mip is the captured lines
  assign irq_qual = irq_q & mie_i;              // Local enable per line

  // Wake-up sees the raw lines, works with no clock running
  // Global enable is not part of it
  assign irq_wu_o = |(irq_i & IRQ_MASK & mie_i);

  // Request only when something is enabled and MIE is set
  assign irq_req_o = (|irq_qual) & m_irq_enable_i;

  ////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////

  // Lowest priority first, each later match overrides
  // Final order is custom 31..16, then MEI, MSI, MTI
  always_comb begin
    irq_id_o = CSR_MTIX_BIT;                    // Default also when nothing pends
    if (irq_qual[CSR_MSIX_BIT]) begin
      irq_id_o = CSR_MSIX_BIT;
    end
    if (irq_qual[CSR_MEIX_BIT]) begin
      irq_id_o = CSR_MEIX_BIT;
    end
    for (int i = 16; i < 32; i++) begin         // Higher custom index wins
      if (irq_qual[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

endmodule

// File: verilog/csr_unit.sv
`timescale 1ns/1ns

module csr_unit #(
  parameter logic [31:0] IRQ_MASK = irq_pkg::IRQ_MASK_DEFAULT  // Writable mie bits
) (
  input  logic                clk,
  input  logic                rst_n,

  // CSR access port from the core
  input  logic                csr_we_i,         // Write strobe
  input  irq_pkg::csr_addr_t  csr_addr_i,
  input  logic [31:0]         csr_wdata_i,
  output logic [31:0]         csr_rdata_o,      // Combinational read

  // From the interrupt controller
  input  logic [31:0]         mip_i,

  // Side updates from trap control
  input  logic                take_irq_i,       // Interrupt entry strobe
  input  irq_pkg::irq_id_t    irq_id_i,         // Cause of the entry
  input  logic                do_mret_i,        // Return strobe
  input  logic [31:0]         trap_pc_i,        // Next pc at the boundary

  // CSR state to the other blocks
  output logic [31:0]         mie_o,
  output logic                mstatus_mie_o,
  output logic [31:0]         mtvec_o,
  output logic [31:0]         mepc_o
);

  import irq_pkg::*;

  logic        mstatus_mie_q;                   // Global enable
  logic        mstatus_mpie_q;                  // Saved enable
  logic [31:0] mie_q;
  logic [31:0] mtvec_q;                         // Base in 31:2, mode in 1:0
  logic [31:0] mepc_q;
  logic [31:0] mcause_q;

  logic        mstatus_we;                      // Port write decode
  logic        mie_we;
  logic        mtvec_we;
  logic        mepc_we;
  logic        mcause_we;

  logic [31:0] mstatus_rd;                      // mstatus as seen by a read

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////

  // One strobe per register, unknown addresses hit nothing
  always_comb begin
    mstatus_we = 1'b0;
    mie_we     = 1'b0;
    mtvec_we   = 1'b0;
    mepc_we    = 1'b0;
    mcause_we  = 1'b0;
    if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: mstatus_we = 1'b1;
        CSR_MIE:     mie_we     = 1'b1;
        CSR_MTVEC:   mtvec_we   = 1'b1;
        CSR_MEPC:    mepc_we    = 1'b1;
        CSR_MCAUSE:  mcause_we  = 1'b1;
        default: ;                              // mip and others are read only
      endcase
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  // mstatus, trap entry and mret take precedence over the port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie_q  <= 1'b0;                   // Interrupts start disabled
      mstatus_mpie_q <= 1'b0;
    end else if (take_irq_i) begin
      mstatus_mpie_q <= mstatus_mie_q;          // Save current enable
      mstatus_mie_q  <= 1'b0;                   // Handler runs with MIE off
    end else if (do_mret_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;         // Restore
      mstatus_mpie_q <= 1'b1;
    end else if (mstatus_we) begin
      mstatus_mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
    end
  end

  // Port-only registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q   <= '0;
      mtvec_q <= '0;
    end else begin
      if (mie_we) begin
        mie_q <= csr_wdata_i & IRQ_MASK;        // Unimplemented bits stay zero
      end
      if (mtvec_we) begin
        // Mode 1 is vectored, anything else falls back to direct
        mtvec_q <= {csr_wdata_i[31:2], 1'b0, (csr_wdata_i[1:0] == 2'b01)};
      end
    end
  end

  // mepc and mcause, written by trap entry or by the port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (take_irq_i) begin
      mepc_q   <= {trap_pc_i[31:1], 1'b0};
      mcause_q <= {1'b1, 26'd0, irq_id_i};      // Interrupt flag plus id
    end else begin
      if (mepc_we) begin
        mepc_q <= {csr_wdata_i[31:1], 1'b0};    // Halfword aligned at least
      end
      if (mcause_we) begin
        mcause_q <= {csr_wdata_i[31], 26'd0, csr_wdata_i[4:0]};
      end
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb begin
    mstatus_rd                   = '0;          // Other fields hardwired low
    mstatus_rd[MSTATUS_MIE_BIT]  = mstatus_mie_q;
    mstatus_rd[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
  end

  always_comb begin
    case (csr_addr_i)
      CSR_MSTATUS: csr_rdata_o = mstatus_rd;
      CSR_MIE:     csr_rdata_o = mie_q;
      CSR_MTVEC:   csr_rdata_o = mtvec_q;
      CSR_MEPC:    csr_rdata_o = mepc_q;
      CSR_MCAUSE:  csr_rdata_o = mcause_q;
      CSR_MIP:     csr_rdata_o = mip_i;         // Live pending lines
      default:     csr_rdata_o = '0;            // Unknown address
    endcase
  end

  // State out to the other blocks
  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;
  assign mtvec_o       = mtvec_q;
  assign mepc_o        = mepc_q;

endmodule

// File: verilog/trap_ctrl.sv
`timescale 1ns/1ns

module trap_ctrl (
  input  logic              clk,
  input  logic              rst_n,

  // Boundary interface from the core
  input  logic              boundary_i,         // Core can be interrupted now
  input  logic              mret_i,             // Only valid with boundary_i
  input  logic [31:0]       pc_i,               // Next instruction address

  // From the interrupt controller
  input  logic              irq_req_i,          // Already globally qualified
  input  irq_pkg::irq_id_t  irq_id_i,

  // From the CSR unit
  input  logic [31:0]       mtvec_i,
  input  logic [31:0]       mepc_i,

  // Side update strobes to the CSR unit
  output logic              take_irq_o,
  output logic              do_mret_o,

  // Redirect to the core, one cycle after the boundary
  output logic              redirect_o,
  output logic [31:0]       redirect_pc_o,
  output logic [31:0]       redirect_cause_o
);

  logic [31:0] mtvec_base;                      // mtvec with mode bits cleared
  logic [31:0] vec_offset;                      // Four times the id
  logic [31:0] irq_target;                      // Handler address
  logic [31:0] target_d;                        // Next redirect pc
  logic [31:0] cause_d;                         // Next redirect cause
  logic        redirect_d;

  logic        redirect_q;
  logic [31:0] redirect_pc_q;
  logic [31:0] redirect_cause_q;

  ////////////////////////////////////////
  // Decision
  ////////////////////////////////////////

  // Interrupt wins, a dropped mret gets presented again by the core
  assign take_irq_o = boundary_i & irq_req_i;
  assign do_mret_o  = boundary_i & mret_i & ~irq_req_i;
  assign redirect_d = take_irq_o | do_mret_o;

  ////////////////////////////////////////
  // Target and cause
  ////////////////////////////////////////

  assign mtvec_base = {mtvec_i[31:2], 2'b00};
  assign vec_offset = {25'd0, irq_id_i, 2'b00};

  // Mode 1 jumps into the vector table, mode 0 to the base
  assign irq_target = (mtvec_i[1:0] == 2'b01) ? (mtvec_base + vec_offset)
                                              : mtvec_base;

  always_comb begin
    if (take_irq_o) begin
      target_d = irq_target;
      cause_d  = {1'b1, 26'd0, irq_id_i};       // Interrupt flag plus id
    end else begin
      target_d = mepc_i;                        // mret returns to mepc
      cause_d  = '0;
    end
  end

  ////////////////////////////////////////
  // Redirect registers
  ////////////////////////////////////////

  // Strobe is high for one cycle per decision
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= redirect_d;
    end
  end

  // Payload only loads on a decision
  always_ff @(posedge clk) begin
    if (redirect_d) begin
      redirect_pc_q    <= target_d;
      redirect_cause_q <= cause_d;
    end
  end

  assign redirect_o       = redirect_q;
  assign redirect_pc_o    = redirect_pc_q;
  assign redirect_cause_o = redirect_cause_q;

endmodule

// File: verilog/irq_subsys_top.sv
`timescale 1ns/1ns

module irq_subsys_top #(
  parameter logic [31:0] IRQ_MASK = irq_pkg::IRQ_MASK_DEFAULT  // Implemented lines
) (
  input  logic                clk,
  input  logic                rst_n,

  // Interrupt lines and wake-up
  input  logic [31:0]         irq_i,
  output logic                irq_wu_o,

  // CSR port
  input  logic                csr_we_i,
  input  irq_pkg::csr_addr_t  csr_addr_i,
  input  logic [31:0]         csr_wdata_i,
  output logic [31:0]         csr_rdata_o,

  // Core boundary
  input  logic                boundary_i,
  input  logic                mret_i,
  input  logic [31:0]         pc_i,

  // Redirect to the core
  output logic                redirect_o,
  output logic [31:0]         redirect_pc_o,
  output logic [31:0]         redirect_cause_o
);

  import irq_pkg::*;

  logic [31:0] mip;                             // Captured lines
  logic        irq_req;
  irq_id_t     irq_id;
  logic [31:0] mie;
  logic        mstatus_mie;                     // Global enable
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic        take_irq;                        // Entry strobe
  logic        do_mret;                         // Return strobe

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  irq_ctrl #(
    .IRQ_MASK       (IRQ_MASK)
  ) irq_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .mie_i          (mie),
    .m_irq_enable_i (mstatus_mie),
    .mip_o          (mip),
    .irq_req_o      (irq_req),
    .irq_id_o       (irq_id),
    .irq_wu_o       (irq_wu_o)
  );

  csr_unit #(
    .IRQ_MASK       (IRQ_MASK)                  // Same mask limits mie
  ) csr_unit_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_we_i       (csr_we_i),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_i),
    .csr_rdata_o    (csr_rdata_o),
    .mip_i          (mip),
    .take_irq_i     (take_irq),
    .irq_id_i       (irq_id),
    .do_mret_i      (do_mret),
    .trap_pc_i      (pc_i),                     // mepc source at entry
    .mie_o          (mie),
    .mstatus_mie_o  (mstatus_mie),
    .mtvec_o        (mtvec),
    .mepc_o         (mepc)
  );

  trap_ctrl trap_ctrl_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .boundary_i       (boundary_i),
    .mret_i           (mret_i),
    .pc_i             (pc_i),
    .irq_req_i        (irq_req),
    .irq_id_i         (irq_id),
    .mtvec_i          (mtvec),
    .mepc_i           (mepc),
    .take_irq_o       (take_irq),
    .do_mret_o        (do_mret),
    .redirect_o       (redirect_o),
    .redirect_pc_o    (redirect_pc_o),
    .redirect_cause_o (redirect_cause_o)
  );

endmodule

// File: testbench/tb_irq_model.svh
`ifndef TB_IRQ_MODEL_SVH
`define TB_IRQ_MODEL_SVH

  ////////////////////////////////////////
  // Reference state, stepped every edge
  ////////////////////////////////////////

  localparam logic [31:0] IMPL_LINES = 32'hffff_0888;  // Custom 31..16, MEI, MTI, MSI

  logic [31:0] m_mip;                           // Lines as captured at the last edge
  logic [31:0] m_mie;
  logic        m_en;                            // mstatus.MIE
  logic        m_mpie;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic        exp_redirect;                    // Prediction for the cycle after an edge
  logic [31:0] exp_pc;
  logic [31:0] exp_cause_v;

  // Custom lines from 31 down win, then MEI, MSI and MTI last
  function automatic logic [4:0] exp_irq_id(input logic [31:0] qual);
    logic [4:0] id;
    logic       found;
    id    = 5'd0;
    found = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (qual[i] && !found) begin
        id    = 5'(i);
        found = 1'b1;
      end
    end
    if (!found) begin
      id = qual[11] ? 5'd11 : (qual[3] ? 5'd3 : 5'd7);
    end
    return id;
  endfunction

  // Direct mode jumps to the base, vectored mode adds four per id
  function automatic logic [31:0] exp_target(input logic [31:0] tvec, input logic [4:0] id);
    logic [31:0] base;
    base = {tvec[31:2], 2'b00};
    return (tvec[1:0] == 2'b01) ? base + 32'(id) * 4 : base;
  endfunction

  function automatic logic [31:0] exp_cause(input logic [4:0] id);
    return 32'h8000_0000 | 32'(id);             // Interrupt flag in bit 31
  endfunction

  task automatic model_reset();
    {m_mip, m_mie, m_en, m_mpie, m_mtvec, m_mepc} = '0;
    {exp_redirect, exp_pc, exp_cause_v} = '0;
  endtask

  // One rising edge worth of CSR and redirect behavior
  task automatic model_step();
    logic take;
    logic mret;
    logic old_en;
    logic old_mpie;
    logic [4:0] id;
    take     = boundary_i && m_en && |(m_mip & m_mie);
    mret     = boundary_i && mret_i && !take;  // Interrupt beats mret
    id       = exp_irq_id(m_mip & m_mie);
    old_en   = m_en;
    old_mpie = m_mpie;
    exp_redirect = take || mret;
    exp_pc       = take ? exp_target(m_mtvec, id) : m_mepc;
    exp_cause_v  = take ? exp_cause(id) : 32'h0;
    if (csr_we_i) begin
      case (csr_addr_i)
        CSR_MSTATUS: {m_mpie, m_en} = {csr_wdata_i[7], csr_wdata_i[3]};
        CSR_MIE:     m_mie = csr_wdata_i & IMPL_LINES;
        CSR_MTVEC:   m_mtvec = {csr_wdata_i[31:2], 1'b0, csr_wdata_i[1:0] == 2'b01};
        CSR_MEPC:    m_mepc = {csr_wdata_i[31:1], 1'b0};
        default: ;
      endcase
    end
    if (take) begin                             // Side updates override the port
      m_mpie = old_en;
      m_en   = 1'b0;
      m_mepc = {pc_i[31:1], 1'b0};
    end else if (mret) begin
      m_en   = old_mpie;
      m_mpie = 1'b1;
    end
    m_mip = irq_i & IMPL_LINES;
  endtask

`endif

// File: testbench/tb_irq_subsys.sv
`timescale 1ns/1ns

module tb_irq_subsys;

  import irq_pkg::*;

  localparam int          CLK_PERIOD  = 20;
  localparam logic [31:0] SEED        = 32'hea0b44e7;
  localparam int          N_ITER      = 16;
  localparam int          TEST_CYCLES = N_ITER * 29 + 40;   // Sum over the six tests
  localparam int          TIMEOUT_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic [31:0] irq_i;
  logic        irq_wu_o;
  logic        csr_we_i;
  csr_addr_t   csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        boundary_i;
  logic        mret_i;
  logic [31:0] pc_i;
  logic        redirect_o;
  logic [31:0] redirect_pc_o;
  logic [31:0] redirect_cause_o;
  int          errors = 0;
  int          checks = 0;

  `include "tb_irq_model.svh"

  irq_subsys_top irq_subsys_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests still running after %0d ns, run stopped", TIMEOUT_NS);
    $display("Simulation FAILED");
    $finish;
  end

  always @(posedge clk) begin
    if (!rst_n) model_reset();
    else model_step();
  end

  // Redirect compare, outputs settled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      checks++;
      if (redirect_o !== exp_redirect) begin
        $display("CHECK FAILED at %0t: redirect_o %b, expected %b", $time, redirect_o,
                 exp_redirect);
        errors++;
      end else if (exp_redirect && (redirect_pc_o !== exp_pc ||
                                    redirect_cause_o !== exp_cause_v)) begin
        $display("CHECK FAILED at %0t: redirect to %h cause %h, expected %h cause %h",
                 $time, redirect_pc_o, redirect_cause_o, exp_pc, exp_cause_v);
        errors++;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;                                         // Drive just after the edge
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic csr_write(input csr_addr_t addr, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    next_cycle();
    csr_we_i    = 1'b0;
  endtask

  task automatic csr_expect(input csr_addr_t addr, input logic [31:0] exp, input string what);
    csr_addr_i = addr;
    @(negedge clk);
    check_value(what, csr_rdata_o, exp);
    next_cycle();
  endtask

  // Boundary cycle plus the redirect cycle that follows
  task automatic boundary_at(input logic [31:0] pc, input logic mret);
    boundary_i = 1'b1;
    pc_i       = pc;
    mret_i     = mret;
    next_cycle();
    boundary_i = 1'b0;
    mret_i     = 1'b0;
    next_cycle();
  endtask

  task automatic end_test(input string name, input int err_start);
    $display("Test %s done, %0d errors", name, errors - err_start);
  endtask

  initial begin
    int          e;
    int          id;
    int          pick;
    int          seed;
    logic [31:0] r;
    logic [31:0] m;
    logic [31:0] pc;
    seed = SEED;
    r    = $urandom(seed);                      // Seeds the generator once
    {rst_n, irq_i, csr_we_i, csr_addr_i, csr_wdata_i, boundary_i, mret_i, pc_i} = '0;
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;

    e = errors;                                 // mip follows the masked lines
    for (int i = 0; i < N_ITER; i++) begin
      r     = $urandom;
      irq_i = r;
      next_cycle();
      csr_expect(CSR_MIP, r & IMPL_LINES, "mip");
    end
    end_test("mip capture", e);

    e = errors;
    irq_i = '0;
    csr_write(CSR_MTVEC, 32'h0000_0100);
    for (int i = 0; i < N_ITER; i++) begin
      m  = $urandom | 32'h0000_0888;            // Standard lines always enabled
      r  = $urandom;
      pc = $urandom;
      if (r[0]) r[31:16] = 16'h0;               // Let the standard lines compete
      if (r[1]) r[11] = 1'b0;
      if (r[2]) r[3] = 1'b0;
      r = r | (32'h8 << (4 * ($urandom % 3)));
      csr_write(CSR_MIE, m);
      csr_write(CSR_MSTATUS, 32'h8);
      irq_i = r;
      next_cycle();
      boundary_at(pc, 1'b0);
      irq_i = '0;
      csr_expect(CSR_MEPC, {pc[31:1], 1'b0}, "mepc");
      csr_expect(CSR_MSTATUS, 32'h80, "mstatus after entry");
    end
    end_test("interrupt entry", e);

    e = errors;
    for (int i = 0; i < N_ITER; i++) begin
      m = $urandom;
      r = $urandom;
      csr_write(CSR_MIE, m);
      if (i % 2 == 0) begin
        csr_write(CSR_MSTATUS, 32'h0);          // Global enable off
      end else begin
        csr_write(CSR_MSTATUS, 32'h8);
        r = r & ~m;                             // Nothing qualified
      end
      irq_i = r;
      @(negedge clk);
      check_value("irq_wu_o", irq_wu_o, |(r & m & IMPL_LINES));
      next_cycle();
      boundary_at($urandom, 1'b0);
    end
    irq_i = '0;
    end_test("no redirect", e);

    e = errors;
    for (int i = 0; i < N_ITER; i++) begin
      csr_write(CSR_MEPC, $urandom & ~32'h1);
      if (i % 2 == 0) begin
        csr_write(CSR_MSTATUS, 32'h80);         // MPIE set, MIE comes back on
        boundary_at(32'h0, 1'b1);
        csr_expect(CSR_MSTATUS, 32'h88, "mstatus after mret");
      end else begin
        csr_write(CSR_MSTATUS, 32'h0);          // MPIE clear, MIE stays off
        boundary_at(32'h0, 1'b1);
        csr_expect(CSR_MSTATUS, 32'h80, "mstatus after mret");
      end
    end
    csr_write(CSR_MIE, IMPL_LINES);             // mret against a pending MEI
    csr_write(CSR_MSTATUS, 32'h88);
    irq_i = 32'h800;
    next_cycle();
    boundary_at(32'h200, 1'b1);
    irq_i = '0;
    csr_expect(CSR_MSTATUS, 32'h80, "mstatus after dropped mret");
    csr_expect(CSR_MCAUSE, 32'h8000_000b, "mcause");
    end_test("mret", e);

    e = errors;
    for (int i = 0; i < 2 * N_ITER; i++) begin
      r    = $urandom;
      pick = $urandom % 19;
      if (pick < 16) id = pick + 16;
      else id = (pick == 16) ? 3 : ((pick == 17) ? 7 : 11);
      csr_write(CSR_MTVEC, {r[31:2], 1'b0, i[0]});  // Odd rounds vectored
      csr_write(CSR_MSTATUS, 32'h8);
      irq_i = 32'h1 << id;
      next_cycle();
      boundary_at($urandom, 1'b0);
      irq_i = '0;
    end
    end_test("vector target", e);

    e = errors;
    csr_write(CSR_MIE, 32'hffff_ffff);
    csr_expect(CSR_MIE, IMPL_LINES, "mie");
    csr_write(CSR_MIP, 32'hffff_ffff);          // Read only
    csr_expect(CSR_MIP, 32'h0, "mip");
    csr_write(12'h7c0, $urandom);
    csr_expect(12'h7c0, 32'h0, "unknown csr");
    end_test("csr masking", e);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+testbench
verilog/irq_pkg.sv
verilog/irq_ctrl.sv
verilog/csr_unit.sv
verilog/trap_ctrl.sv
verilog/irq_subsys_top.sv
testbench/tb_irq_subsys.sv
